/* bmc.f */
logic/bmc_pkg.sv
logic/wb_decoder.sv
logic/sys_config.sv
logic/level_checker.sv
logic/irq_controller.sv
logic/switch_debouncer.sv
logic/bmc_top.sv
sim/bmc_tb.sv

/* Bender.yml */
package:
  name: bmc

sources:
  - logic/bmc_pkg.sv
  - logic/wb_decoder.sv
  - logic/sys_config.sv
  - logic/level_checker.sv
  - logic/irq_controller.sv
  - logic/switch_debouncer.sv
  - logic/bmc_top.sv
  - target: test
    files:
      - sim/bmc_tb.sv

/* sim/bmc_tb.sv */
`timescale 1ns/1ns

module bmc_tb;

  localparam int BUS_TIMEOUT = 20; // cycles without ack or err
  localparam int POLL_LIMIT  = 20; // status reads while waiting for the button
  localparam int NUM_ROWS    = 11;

  typedef struct packed {
    bmc_pkg::adc_chan_t  chan;
    bmc_pkg::adc_value_t low;
    bmc_pkg::adc_value_t high;
    bmc_pkg::adc_value_t value;
    logic                rnd; // value drawn at random
  } level_row_t;

  // channel, low, high, sample value, random value
  level_row_t level_table [NUM_ROWS] = '{
    '{3'd0, 12'h100, 12'h200, 12'h100, 1'b0}, // low edge
    '{3'd0, 12'h100, 12'h200, 12'h0FF, 1'b0},
    '{3'd1, 12'h100, 12'h200, 12'h200, 1'b0}, // high edge
    '{3'd1, 12'h100, 12'h200, 12'h201, 1'b0},
    '{3'd2, 12'h000, 12'hFFF, 12'h000, 1'b0},
    '{3'd3, 12'h400, 12'h400, 12'h400, 1'b0}, // single point window
    '{3'd3, 12'h400, 12'h400, 12'h3FF, 1'b0},
    '{3'd4, 12'h200, 12'hA00, 12'h000, 1'b1},
    '{3'd5, 12'h800, 12'h900, 12'h000, 1'b1},
    '{3'd7, 12'h000, 12'h7FF, 12'h000, 1'b1},
    '{3'd6, 12'h010, 12'hFFF, 12'h00F, 1'b0}
  };

  logic                 gclk40;
  logic                 hard_reset;
  bmc_pkg::wb_req_t     wb_req;
  bmc_pkg::wb_rsp_t     wb_rsp;
  bmc_pkg::adc_sample_t adc_sample;
  logic                 chs_powerdown_n;
  bmc_pkg::sys_config_t sys_config;
  logic                 irq;

  bmc_top UUT (
    .gclk40            (gclk40),
    .hard_reset        (hard_reset),
    .wb_req_i          (wb_req),
    .wb_rsp_o          (wb_rsp),
    .adc_sample_i      (adc_sample),
    .chs_powerdown_n_i (chs_powerdown_n),
    .sys_config_o      (sys_config),
    .irq_o             (irq)
  );

  initial begin
    gclk40 = 1'b0;
    forever #4 gclk40 = ~gclk40;
  end

  task automatic stop_on_error();
    $display("test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_data(input string name, input bmc_pkg::wb_data_t exp,
                            input bmc_pkg::wb_data_t act);
    if (act !== exp) begin
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_config(input string name, input bmc_pkg::sys_config_t exp,
                              input bmc_pkg::sys_config_t act);
    if (act !== exp) begin
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_irq(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Mismatch %s: expected %b, actual %b", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Mismatch %s: expected %b, actual %b", name, exp, act);
      stop_on_error();
    end
  endtask

  // inclusive window rule
  function automatic logic in_limits(input bmc_pkg::adc_value_t v,
                                     input bmc_pkg::adc_value_t lo,
                                     input bmc_pkg::adc_value_t hi);
    return (v >= lo) && (v <= hi);
  endfunction

  function automatic bmc_pkg::wb_addr_t thr_addr(input logic high, input int ch);
    bmc_pkg::wb_addr_t base;
    base = high ? bmc_pkg::REG_HIGH_BASE : bmc_pkg::REG_LOW_BASE;
    return bmc_pkg::LEVCHK_BASE + base + bmc_pkg::wb_addr_t'(ch);
  endfunction

  // one classic cycle, returns at the falling edge after the request is dropped
  task automatic bus_cycle(input logic we, input bmc_pkg::wb_addr_t adr,
                           input bmc_pkg::wb_data_t dat, output bmc_pkg::wb_rsp_t rsp);
    int waited;
    waited = 0;
    @(posedge gclk40);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
    @(negedge gclk40);
    while (!(wb_rsp.ack || wb_rsp.err)) begin
      waited++;
      if (waited > BUS_TIMEOUT) begin
        $display("no ack or err for the %s at address %h", we ? "write" : "read", adr);
        stop_on_error();
      end
      @(negedge gclk40);
    end
    rsp = wb_rsp;
    @(posedge gclk40);
    wb_req <= '0;
    @(negedge gclk40);
  endtask

  task automatic wb_write(input bmc_pkg::wb_addr_t adr, input bmc_pkg::wb_data_t dat);
    bmc_pkg::wb_rsp_t rsp;
    bus_cycle(1'b1, adr, dat, rsp);
    check_err($sformatf("err on write to %h", adr), 1'b0, rsp.err);
  endtask

  task automatic wb_read(input bmc_pkg::wb_addr_t adr, output bmc_pkg::wb_rsp_t rsp);
    bus_cycle(1'b0, adr, '0, rsp);
    check_err($sformatf("err on read from %h", adr), 1'b0, rsp.err);
  endtask

  task automatic apply_sample(input bmc_pkg::adc_chan_t ch, input bmc_pkg::adc_value_t val);
    @(posedge gclk40);
    adc_sample <= '{valid: 1'b1, channel: ch, value: val};
    @(posedge gclk40);
    adc_sample.valid <= 1'b0;
  endtask

  initial begin : main_flow
    bmc_pkg::wb_rsp_t                 rsp;
    bmc_pkg::wb_data_t                wdata;
    bmc_pkg::adc_value_t              thr_low  [bmc_pkg::NUM_CHANNELS];
    bmc_pkg::adc_value_t              thr_high [bmc_pkg::NUM_CHANNELS];
    logic [bmc_pkg::NUM_CHANNELS-1:0] exp_in_range;
    level_row_t                       row;
    logic                             ok;
    int                               polls;

    wb_req          = '0;
    adc_sample      = '0;
    chs_powerdown_n = 1'b1; // button released
    hard_reset      = 1'b0;
    void'($urandom(32'h6e84));
    exp_in_range = '1;
    repeat (5) @(posedge gclk40);
    hard_reset <= 1'b1;

    wb_read(bmc_pkg::SYSCONF_BASE + bmc_pkg::REG_CONFIG, rsp);
    check_data("config after reset", '0, rsp.dat);
    check_irq("irq after reset", 1'b0, irq);
    wdata = bmc_pkg::wb_data_t'($urandom);
    wb_write(bmc_pkg::SYSCONF_BASE + bmc_pkg::REG_CONFIG, wdata);
    check_config("config output", bmc_pkg::sys_config_t'(wdata), sys_config);
    wb_read(bmc_pkg::SYSCONF_BASE + bmc_pkg::REG_CONFIG, rsp);
    check_data("config readback", {8'h00, wdata[7:0]}, rsp.dat);
    wb_write(bmc_pkg::SYSCONF_BASE + bmc_pkg::REG_BOARD_ID, bmc_pkg::wb_data_t'($urandom));
    check_config("config after id write", bmc_pkg::sys_config_t'(wdata), sys_config);
    wb_read(bmc_pkg::SYSCONF_BASE + bmc_pkg::REG_BOARD_ID, rsp);
    check_data("board id", 16'h00B3, rsp.dat);

    // all sixteen thresholds
    for (int ch = 0; ch < bmc_pkg::NUM_CHANNELS; ch++) begin
      thr_low[ch]  = bmc_pkg::adc_value_t'($urandom);
      thr_high[ch] = bmc_pkg::adc_value_t'($urandom);
      wb_write(thr_addr(1'b0, ch), {4'h0, thr_low[ch]});
      wb_write(thr_addr(1'b1, ch), {4'h0, thr_high[ch]});
    end
    for (int ch = 0; ch < bmc_pkg::NUM_CHANNELS; ch++) begin
      wb_read(thr_addr(1'b0, ch), rsp);
      check_data($sformatf("low threshold %0d", ch), {4'h0, thr_low[ch]}, rsp.dat);
      wb_read(thr_addr(1'b1, ch), rsp);
      check_data($sformatf("high threshold %0d", ch), {4'h0, thr_high[ch]}, rsp.dat);
    end

    wb_write(bmc_pkg::SYSCONF_BASE + bmc_pkg::REG_CONFIG, 16'h0001 << bmc_pkg::CFG_CHECK_EN);
    for (int r = 0; r < NUM_ROWS; r++) begin
      row = level_table[r];
      if (row.rnd) begin
        row.value = bmc_pkg::adc_value_t'($urandom);
      end
      wb_write(thr_addr(1'b0, row.chan), {4'h0, row.low});
      wb_write(thr_addr(1'b1, row.chan), {4'h0, row.high});
      apply_sample(row.chan, row.value);
      ok = in_limits(row.value, row.low, row.high);
      exp_in_range[row.chan] = ok;
      wb_read(bmc_pkg::LEVCHK_BASE + bmc_pkg::REG_IN_RANGE, rsp);
      check_data($sformatf("in_range row %0d", r), {8'h00, exp_in_range}, rsp.dat);
      wb_read(bmc_pkg::IRQC_BASE + bmc_pkg::REG_STATUS, rsp);
      check_data($sformatf("violation row %0d", r),
                 bmc_pkg::wb_data_t'(!ok) << bmc_pkg::IRQ_LEVEL, rsp.dat);
      wb_write(bmc_pkg::IRQC_BASE + bmc_pkg::REG_STATUS, 16'h0001 << bmc_pkg::IRQ_LEVEL);
    end

    // checker off, out of range sample on channel 2 must be ignored
    wb_write(bmc_pkg::SYSCONF_BASE + bmc_pkg::REG_CONFIG, 16'h0000);
    wb_write(thr_addr(1'b1, 2), 16'h00FF);
    apply_sample(3'd2, 12'h800);
    wb_read(bmc_pkg::LEVCHK_BASE + bmc_pkg::REG_IN_RANGE, rsp);
    check_data("in_range while disabled", {8'h00, exp_in_range}, rsp.dat);
    wb_read(bmc_pkg::IRQC_BASE + bmc_pkg::REG_STATUS, rsp);
    check_data("status while disabled", '0, rsp.dat);

    wb_write(bmc_pkg::IRQC_BASE + bmc_pkg::REG_MASK, 16'h0001 << bmc_pkg::IRQ_LEVEL);
    wb_write(bmc_pkg::SYSCONF_BASE + bmc_pkg::REG_CONFIG, 16'h0001 << bmc_pkg::CFG_CHECK_EN);
    apply_sample(3'd2, 12'h800);
    wb_read(bmc_pkg::IRQC_BASE + bmc_pkg::REG_STATUS, rsp);
    check_data("level status", 16'h0001 << bmc_pkg::IRQ_LEVEL, rsp.dat);
    check_irq("irq on level event", 1'b1, irq);
    wb_write(bmc_pkg::IRQC_BASE + bmc_pkg::REG_STATUS, 16'h0001 << bmc_pkg::IRQ_LEVEL);
    wb_read(bmc_pkg::IRQC_BASE + bmc_pkg::REG_STATUS, rsp);
    check_data("status after clear", '0, rsp.dat);
    check_irq("irq after clear", 1'b0, irq);

    bus_cycle(1'b0, 16'h0300, '0, rsp); // outside every region
    check_err("unmapped err", 1'b1, rsp.err);
    check_data("unmapped data", '0, rsp.dat);
    wb_read(bmc_pkg::IRQC_BASE + bmc_pkg::REG_STATUS, rsp);
    check_data("bus error status", 16'h0001 << bmc_pkg::IRQ_BUSERR, rsp.dat);
    check_irq("masked out bus error", 1'b0, irq);
    wb_write(bmc_pkg::IRQC_BASE + bmc_pkg::REG_STATUS, 16'h0001 << bmc_pkg::IRQ_BUSERR);

    // short glitch on the power button
    @(posedge gclk40);
    chs_powerdown_n <= 1'b0;
    repeat (5) @(posedge gclk40);
    chs_powerdown_n <= 1'b1;
    repeat (2 * bmc_pkg::DEBOUNCE_CYCLES) @(posedge gclk40);
    wb_read(bmc_pkg::IRQC_BASE + bmc_pkg::REG_STATUS, rsp);
    check_data("status after glitch", '0, rsp.dat);

    @(posedge gclk40);
    chs_powerdown_n <= 1'b0;
    repeat (40) @(posedge gclk40);
    chs_powerdown_n <= 1'b1;
    polls = 0;
    wb_read(bmc_pkg::IRQC_BASE + bmc_pkg::REG_STATUS, rsp);
    while (!rsp.dat[bmc_pkg::IRQ_BUTTON]) begin
      polls++;
      if (polls > POLL_LIMIT) begin
        $display("power button press never reached the interrupt status");
        stop_on_error();
      end
      wb_read(bmc_pkg::IRQC_BASE + bmc_pkg::REG_STATUS, rsp);
    end
    check_data("button status", 16'h0001 << bmc_pkg::IRQ_BUTTON, rsp.dat);
    check_irq("masked out button", 1'b0, irq);

    $display("test passed");
    $finish;
  end

endmodule

/* logic/bmc_top.sv */
`timescale 1ns/1ns

module bmc_top (
  input  logic                 gclk40,
  input  logic                 hard_reset,
  input  bmc_pkg::wb_req_t     wb_req_i,
  output bmc_pkg::wb_rsp_t     wb_rsp_o,
  input  bmc_pkg::adc_sample_t adc_sample_i,
  input  logic                 chs_powerdown_n_i,
  output bmc_pkg::sys_config_t sys_config_o,
  output logic                 irq_o
);

  bmc_pkg::wb_req_t               s_req;
  logic [bmc_pkg::NUM_SLAVES-1:0] s_sel;
  bmc_pkg::wb_rsp_t               sysconf_rsp;
  bmc_pkg::wb_rsp_t               levchk_rsp;
  bmc_pkg::wb_rsp_t               irqc_rsp;
  bmc_pkg::sys_config_t           sys_config;
  bmc_pkg::irq_vec_t              irq_src;
  logic                           unmapped;
  logic                           level_viol;
  logic                           button_press;

  wb_decoder wb_decoder_inst (
    .gclk40        (gclk40),
    .hard_reset    (hard_reset),
    .m_req_i       (wb_req_i),
    .m_rsp_o       (wb_rsp_o),
    .s_req_o       (s_req),
    .s_sel_o       (s_sel),
    .sysconf_rsp_i (sysconf_rsp),
    .levchk_rsp_i  (levchk_rsp),
    .irqc_rsp_i    (irqc_rsp),
    .unmapped_o    (unmapped)
  );

  sys_config sys_config_inst (
    .gclk40       (gclk40),
    .hard_reset   (hard_reset),
    .req_i        (s_req),
    .sel_i        (s_sel[bmc_pkg::SEL_SYSCONF]),
    .rsp_o        (sysconf_rsp),
    .sys_config_o (sys_config)
  );

  level_checker level_checker_inst (
    .gclk40      (gclk40),
    .hard_reset  (hard_reset),
    .req_i       (s_req),
    .sel_i       (s_sel[bmc_pkg::SEL_LEVCHK]),
    .rsp_o       (levchk_rsp),
    .check_en_i  (sys_config[bmc_pkg::CFG_CHECK_EN]),
    .sample_i    (adc_sample_i),
    .violation_o (level_viol)
  );

  switch_debouncer debouncer_pwr_inst (
    .gclk40     (gclk40),
    .hard_reset (hard_reset),
    .button_n_i (chs_powerdown_n_i),
    .press_o    (button_press)
  );

  // event pulses in package bit order
  assign irq_src[bmc_pkg::IRQ_LEVEL]  = level_viol;
  assign irq_src[bmc_pkg::IRQ_BUTTON] = button_press;
  assign irq_src[bmc_pkg::IRQ_BUSERR] = unmapped;

  irq_controller irq_controller_inst (
    .gclk40     (gclk40),
    .hard_reset (hard_reset),
    .req_i      (s_req),
    .sel_i      (s_sel[bmc_pkg::SEL_IRQC]),
    .rsp_o      (irqc_rsp),
    .irq_src_i  (irq_src),
    .irq_o      (irq_o)
  );

  assign sys_config_o = sys_config;

endmodule

/* logic/switch_debouncer.sv */
`timescale 1ns/1ns

module switch_debouncer (
  input  logic gclk40,
  input  logic hard_reset,
  input  logic button_n_i,
  output logic press_o
);

  typedef enum logic {
    BTN_RELEASED,
    BTN_PRESSED
  } btn_state_t;

  logic                                      sync1_q;
  logic                                      sync2_q;
  btn_state_t                                state_q;
  btn_state_t                                level;
  logic [$clog2(bmc_pkg::DEBOUNCE_CYCLES)-1:0] count_q;
  logic                                      press_q;

  assign level = sync2_q ? BTN_RELEASED : BTN_PRESSED; // active low button

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      sync1_q <= 1'b1; // idle released
      sync2_q <= 1'b1;
      state_q <= BTN_RELEASED;
      count_q <= '0;
      press_q <= 1'b0;
    end else begin
      sync1_q <= button_n_i;
      sync2_q <= sync1_q;
      press_q <= 1'b0;
      if (level == state_q) begin
        count_q <= '0; // glitch over, start again
      end else if (count_q == bmc_pkg::DEBOUNCE_CYCLES - 1) begin
        count_q <= '0;
        state_q <= level;
        press_q <= (level == BTN_PRESSED);
      end else begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  assign press_o = press_q;

endmodule

/* logic/irq_controller.sv */
`timescale 1ns/1ns

module irq_controller (
  input  logic              gclk40,
  input  logic              hard_reset,
  input  bmc_pkg::wb_req_t  req_i,
  input  logic              sel_i,
  output bmc_pkg::wb_rsp_t  rsp_o,
  input  bmc_pkg::irq_vec_t irq_src_i,
  output logic              irq_o
);

  bmc_pkg::wb_addr_t  offs;
  logic               access;
  logic               ack_q;
  logic               status_wr;
  bmc_pkg::irq_vec_t  clr;
  bmc_pkg::irq_vec_t  status_q;
  bmc_pkg::irq_vec_t  mask_q;
  bmc_pkg::wb_data_t  rdata_q;
  logic               irq_q;

  assign offs      = req_i.adr - bmc_pkg::IRQC_BASE;
  assign access    = sel_i & ~ack_q;
  assign status_wr = access & req_i.we & (offs == bmc_pkg::REG_STATUS);
  assign clr       = status_wr ? bmc_pkg::irq_vec_t'(req_i.dat) : '0; // write one to clear

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      ack_q    <= 1'b0;
      status_q <= '0;
      mask_q   <= '0;
      irq_q    <= 1'b0;
    end else begin
      ack_q    <= access;
      status_q <= (status_q & ~clr) | irq_src_i; // new event wins over clear
      irq_q    <= |(status_q & mask_q);
      if (access && req_i.we && offs == bmc_pkg::REG_MASK) begin
        mask_q <= bmc_pkg::irq_vec_t'(req_i.dat);
      end
    end
  end

  always_ff @(posedge gclk40) begin
    if (access && !req_i.we) begin
      case (offs)
        bmc_pkg::REG_STATUS: rdata_q <= bmc_pkg::wb_data_t'(status_q);
        bmc_pkg::REG_MASK:   rdata_q <= bmc_pkg::wb_data_t'(mask_q);
        default:             rdata_q <= '0;
      endcase
    end
  end

  assign rsp_o.ack = ack_q;
  assign rsp_o.err = 1'b0;
  assign rsp_o.dat = rdata_q;
  assign irq_o     = irq_q;

  // sticky bits only drop after a status write
  assert property (@(posedge gclk40) disable iff (!hard_reset)
    (|($past(status_q) & ~status_q)) |-> $past(status_wr));

endmodule

/* logic/level_checker.sv */
`timescale 1ns/1ns

module level_checker (
  input  logic                 gclk40,
  input  logic                 hard_reset,
  input  bmc_pkg::wb_req_t     req_i,
  input  logic                 sel_i,
  output bmc_pkg::wb_rsp_t     rsp_o,
  input  logic                 check_en_i,
  input  bmc_pkg::adc_sample_t sample_i,
  output logic                 violation_o
);

  bmc_pkg::adc_value_t             low_thr  [bmc_pkg::NUM_CHANNELS];
  bmc_pkg::adc_value_t             high_thr [bmc_pkg::NUM_CHANNELS];
  logic [bmc_pkg::NUM_CHANNELS-1:0] in_range_q;

  bmc_pkg::wb_addr_t   offs;
  bmc_pkg::adc_chan_t  thr_idx;
  logic                is_thr;
  logic                is_high;
  logic                access;
  logic                ack_q;
  bmc_pkg::wb_data_t   rdata_q;
  logic                sample_ok;
  logic                violation_q;

  assign offs    = req_i.adr - bmc_pkg::LEVCHK_BASE;
  assign is_thr  = offs < bmc_pkg::REG_IN_RANGE; // 0x00..0x0F
  assign is_high = offs >= bmc_pkg::REG_HIGH_BASE;
  assign thr_idx = bmc_pkg::adc_chan_t'(offs);
  assign access  = sel_i & ~ack_q;

  // inclusive on both ends
  assign sample_ok = (sample_i.value >= low_thr[sample_i.channel]) &&
                     (sample_i.value <= high_thr[sample_i.channel]);

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      ack_q       <= 1'b0;
      violation_q <= 1'b0;
      in_range_q  <= '1;
      for (int i = 0; i < bmc_pkg::NUM_CHANNELS; i++) begin
        low_thr[i]  <= '0;
        high_thr[i] <= bmc_pkg::ADC_MAX;
      end
    end else begin
      ack_q       <= access;
      violation_q <= 1'b0;
      if (access && req_i.we && is_thr) begin
        if (is_high) begin
          high_thr[thr_idx] <= bmc_pkg::adc_value_t'(req_i.dat);
        end else begin
          low_thr[thr_idx]  <= bmc_pkg::adc_value_t'(req_i.dat);
        end
      end
      // disabled checker leaves in_range frozen
      if (sample_i.valid && check_en_i) begin
        in_range_q[sample_i.channel] <= sample_ok;
        violation_q                  <= ~sample_ok;
      end
    end
  end

  always_ff @(posedge gclk40) begin
    if (access && !req_i.we) begin
      if (is_thr && is_high) begin
        rdata_q <= bmc_pkg::wb_data_t'(high_thr[thr_idx]);
      end else if (is_thr) begin
        rdata_q <= bmc_pkg::wb_data_t'(low_thr[thr_idx]);
      end else if (offs == bmc_pkg::REG_IN_RANGE) begin
        rdata_q <= bmc_pkg::wb_data_t'(in_range_q);
      end else begin
        rdata_q <= '0;
      end
    end
  end

  assign rsp_o.ack   = ack_q;
  assign rsp_o.err   = 1'b0;
  assign rsp_o.dat   = rdata_q;
  assign violation_o = violation_q;

  // a violation needs check enable on the sample cycle
  assert property (@(posedge gclk40) disable iff (!hard_reset)
    violation_o |-> $past(check_en_i));

endmodule

/* logic/sys_config.sv */
`timescale 1ns/1ns

module sys_config (
  input  logic                 gclk40,
  input  logic                 hard_reset,
  input  bmc_pkg::wb_req_t     req_i,
  input  logic                 sel_i,
  output bmc_pkg::wb_rsp_t     rsp_o,
  output bmc_pkg::sys_config_t sys_config_o
);

  bmc_pkg::wb_addr_t    offs;
  logic                 access;
  logic                 ack_q;
  bmc_pkg::wb_data_t    rdata_q;
  bmc_pkg::sys_config_t cfg_q;

  assign offs   = req_i.adr - bmc_pkg::SYSCONF_BASE;
  assign access = sel_i & ~ack_q; // first cycle of the access only

  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      ack_q <= 1'b0;
      cfg_q <= '0;
    end else begin
      ack_q <= access;
      // board id writes fall through and are dropped
      if (access && req_i.we && offs == bmc_pkg::REG_CONFIG) begin
        cfg_q <= bmc_pkg::sys_config_t'(req_i.dat);
      end
    end
  end

  always_ff @(posedge gclk40) begin
    if (access && !req_i.we) begin
      case (offs)
        bmc_pkg::REG_CONFIG:   rdata_q <= bmc_pkg::wb_data_t'(cfg_q);
        bmc_pkg::REG_BOARD_ID: rdata_q <= bmc_pkg::BOARD_ID;
        default:               rdata_q <= '0;
      endcase
    end
  end

  assign rsp_o.ack = ack_q;
  assign rsp_o.err = 1'b0;
  assign rsp_o.dat = rdata_q;

  assign sys_config_o = cfg_q; // new value visible in the ack cycle

endmodule

/* logic/wb_decoder.sv */
`timescale 1ns/1ns

module wb_decoder (
  input  logic                            gclk40,
  input  logic                            hard_reset,
  input  bmc_pkg::wb_req_t                m_req_i,
  output bmc_pkg::wb_rsp_t                m_rsp_o,
  output bmc_pkg::wb_req_t                s_req_o,
  output logic [bmc_pkg::NUM_SLAVES-1:0]  s_sel_o,
  input  bmc_pkg::wb_rsp_t                sysconf_rsp_i,
  input  bmc_pkg::wb_rsp_t                levchk_rsp_i,
  input  bmc_pkg::wb_rsp_t                irqc_rsp_i,
  output logic                            unmapped_o
);

  logic [bmc_pkg::NUM_SLAVES-1:0] hit;
  logic                           strobe;
  logic                           err_q;

  function automatic logic in_region(
    input bmc_pkg::wb_addr_t adr,
    input bmc_pkg::wb_addr_t base,
    input bmc_pkg::wb_addr_t high
  );
    in_region = (adr >= base) && (adr <= high);
  endfunction

  assign strobe = m_req_i.cyc & m_req_i.stb;

  assign hit[bmc_pkg::SEL_SYSCONF] =
    in_region(m_req_i.adr, bmc_pkg::SYSCONF_BASE, bmc_pkg::SYSCONF_HIGH);
  assign hit[bmc_pkg::SEL_LEVCHK] =
    in_region(m_req_i.adr, bmc_pkg::LEVCHK_BASE, bmc_pkg::LEVCHK_HIGH);
  assign hit[bmc_pkg::SEL_IRQC] =
    in_region(m_req_i.adr, bmc_pkg::IRQC_BASE, bmc_pkg::IRQC_HIGH);

  // request is shared, only the selected slave sees its strobe through sel
  assign s_req_o = m_req_i;
  assign s_sel_o = hit & {bmc_pkg::NUM_SLAVES{strobe}};

  // unmapped access answered here with a one cycle err
  always_ff @(posedge gclk40) begin
    if (!hard_reset) begin
      err_q <= 1'b0;
    end else begin
      err_q <= strobe & ~(|hit) & ~err_q;
    end
  end

  assign unmapped_o = err_q; // same cycle as err

  always_comb begin
    m_rsp_o = '0;
    if (err_q) begin
      m_rsp_o.err = 1'b1; // data stays zero
    end else if (s_sel_o[bmc_pkg::SEL_SYSCONF]) begin
      m_rsp_o = sysconf_rsp_i;
    end else if (s_sel_o[bmc_pkg::SEL_LEVCHK]) begin
      m_rsp_o = levchk_rsp_i;
    end else if (s_sel_o[bmc_pkg::SEL_IRQC]) begin
      m_rsp_o = irqc_rsp_i;
    end
  end

  // a slave ack must never coincide with the local err
  assert property (@(posedge gclk40) disable iff (!hard_reset)
    !(err_q && (sysconf_rsp_i.ack || levchk_rsp_i.ack || irqc_rsp_i.ack)));

endmodule

/* logic/bmc_pkg.sv */
package bmc_pkg;

  localparam int NUM_CHANNELS = 8;
  localparam int NUM_IRQ      = 3;
  localparam int NUM_SLAVES   = 3;

  // bus and payload widths
  typedef logic [15:0]                       wb_addr_t; // word address, no byte lanes
  typedef logic [15:0]                       wb_data_t;
  typedef logic [11:0]                       adc_value_t;
  typedef logic [$clog2(NUM_CHANNELS)-1:0]   adc_chan_t;
  typedef logic [7:0]                        sys_config_t;
  typedef logic [NUM_IRQ-1:0]                irq_vec_t;

  // slave select positions in the decoder
  localparam int SEL_SYSCONF = 0;
  localparam int SEL_LEVCHK  = 1;
  localparam int SEL_IRQC    = 2;

  // address map, inclusive bounds
  localparam wb_addr_t SYSCONF_BASE = 16'h0000;
  localparam wb_addr_t SYSCONF_HIGH = 16'h000F;
  localparam wb_addr_t LEVCHK_BASE  = 16'h0100;
  localparam wb_addr_t LEVCHK_HIGH  = 16'h01FF;
  localparam wb_addr_t IRQC_BASE    = 16'h0200;
  localparam wb_addr_t IRQC_HIGH    = 16'h020F;

  localparam wb_data_t BOARD_ID        = 16'h00B3;
  localparam int       DEBOUNCE_CYCLES = 16;
  localparam adc_value_t ADC_MAX       = 12'hFFF; // full scale, high threshold after reset

  // interrupt source bit positions
  localparam int IRQ_LEVEL  = 0;
  localparam int IRQ_BUTTON = 1;
  localparam int IRQ_BUSERR = 2;

  // sys_config offsets
  localparam wb_addr_t REG_CONFIG   = 16'h0000;
  localparam wb_addr_t REG_BOARD_ID = 16'h0001;

  // level checker offsets
  localparam wb_addr_t REG_LOW_BASE  = 16'h0000; // eight low thresholds
  localparam wb_addr_t REG_HIGH_BASE = 16'h0008; // eight high thresholds
  localparam wb_addr_t REG_IN_RANGE  = 16'h0010;

  // irq controller offsets
  localparam wb_addr_t REG_STATUS = 16'h0000;
  localparam wb_addr_t REG_MASK   = 16'h0001;

  localparam int CFG_CHECK_EN = 0; // config bit that enables level checking

  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_data_t dat;
  } wb_req_t;

  typedef struct packed {
    logic     ack;
    logic     err;
    wb_data_t dat;
  } wb_rsp_t;

  typedef struct packed {
    logic       valid;
    adc_chan_t  channel;
    adc_value_t value;
  } adc_sample_t;

endpackage
